// File: Bender.yml
package:
  name: rename_unit

export_include_dirs:
  - logic

sources:
  - logic/rename_pkg.sv
  - logic/rename_ctrl.sv
  - logic/fill_counter.sv
  - logic/free_list.sv
  - logic/map_table.sv
  - logic/reorder_buffer.sv
  - logic/rename_unit.sv
  - target: test
    files:
      - tb/rename_unit_sva.sv
      - tb/tb_rename_unit.sv

// File: logic/fill_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module fill_counter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fill_en,
  output rename_pkg::phys_reg_t fill_tag,
  output logic                  fill_last
);
  import rename_pkg::*;

  // Tags below ARCH_REGS belong to the reset map
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fill_tag <= phys_reg_t'(`ARCH_REGS);
    end else if (fill_en && !fill_last) begin
      fill_tag <= fill_tag + 1'b1;
    end
  end

  // Holds at the top tag once reached
  assign fill_last = (fill_tag == phys_reg_t'(`PHYS_REGS - 1));

endmodule

`default_nettype wire

// File: logic/free_list.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module free_list (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push,
  input  rename_pkg::phys_reg_t push_tag,
  input  logic                  pop,
  output rename_pkg::phys_reg_t head_tag,
  output logic                  empty
);
  import rename_pkg::*;

  localparam int PTR_W = $clog2(`PHYS_REGS);

  phys_reg_t        mem [`PHYS_REGS];
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  fl_count_t        count;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) tail <= tail + 1'b1;
      if (pop) head <= head + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[tail] <= push_tag;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  assign head_tag = mem[head];
  assign empty    = (count == '0);

endmodule

`default_nettype wire

// File: logic/map_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module map_table (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rename_pkg::arch_reg_t  src_a,
  input  rename_pkg::arch_reg_t  src_b,
  input  rename_pkg::arch_reg_t  dest,
  input  logic                   write_en,
  input  rename_pkg::phys_reg_t  new_tag,
  input  logic                   comp_tag_valid,
  input  rename_pkg::phys_reg_t  comp_tag,
  output rename_pkg::phys_reg_t  tag_a,
  output rename_pkg::phys_reg_t  tag_b,
  output rename_pkg::phys_reg_t  tag_old,
  output logic                   rdy_a,
  output logic                   rdy_b
);
  import rename_pkg::*;

  phys_reg_t             map [`ARCH_REGS];
  logic [`ARCH_REGS-1:0] ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // Identity mapping, every value committed
      for (int i = 0; i < `ARCH_REGS; i++) begin
        map[i]   <= phys_reg_t'(i);
        ready[i] <= 1'b1;
      end
    end else begin
      // CAM match on the completing tag
      if (comp_tag_valid) begin
        for (int i = 0; i < `ARCH_REGS; i++) begin
          if (map[i] == comp_tag) begin
            ready[i] <= 1'b1;
          end
        end
      end
      // Rename wins over a ready-set of the old tag
      if (write_en) begin
        map[dest]   <= new_tag;
        ready[dest] <= 1'b0;
      end
    end
  end

  // No bypass of same-cycle completion
  assign tag_a   = map[src_a];
  assign rdy_a   = ready[src_a];
  assign tag_b   = map[src_b];
  assign rdy_b   = ready[src_b];
  assign tag_old = map[dest];

endmodule

`default_nettype wire

// File: logic/rename_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rename_ctrl (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            fill_last,
  input  logic            rob_full,
  input  logic            fl_empty,
  input  logic            retire_valid,
  input  rename_pkg::op_e retire_op,
  output logic            fill_en,
  output logic            dispatch_ready,
  output logic            halted
);
  import rename_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_next;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_INIT;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      // Free list is being loaded with the spare tags
      S_INIT: if (fill_last) state_next = S_RUN;
      S_RUN: if (retire_valid && (retire_op == OP_HALT)) state_next = S_HALTED;
      // Halted until the next reset
      default: state_next = state;
    endcase
  end

  assign fill_en = (state == S_INIT);

  // Independent of dispatch_valid
  assign dispatch_ready = (state == S_RUN) && !rob_full && !fl_empty;

  assign halted = (state == S_HALTED);

endmodule

`default_nettype wire

// File: logic/rename_defines.svh
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Architectural register file size
`define ARCH_REGS 32

// Physical tags, including the ones held by the reset map
`define PHYS_REGS 64

`define ROB_DEPTH 16

`endif

// File: logic/rename_pkg.sv
`default_nettype none

`include "rename_defines.svh"

package rename_pkg;

  typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;
  typedef logic [$clog2(`PHYS_REGS)-1:0] phys_reg_t;
  typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_ptr_t;

  // Needs one extra bit to hold a completely full list
  typedef logic [$clog2(`PHYS_REGS + 1)-1:0] fl_count_t;

  typedef enum logic [1:0] {
    S_INIT,
    S_RUN,
    S_HALTED
  } ctrl_state_e;

  // Only OP_ALU writes a destination register
  typedef enum logic [1:0] {
    OP_NOP,
    OP_ALU,
    OP_HALT
  } op_e;

endpackage

`default_nettype wire

// File: logic/rename_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rename_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  dispatch_valid,
  input  rename_pkg::op_e       dispatch_op,
  input  rename_pkg::arch_reg_t dispatch_dest,
  input  rename_pkg::arch_reg_t dispatch_src_a,
  input  rename_pkg::arch_reg_t dispatch_src_b,
  input  logic                  complete_valid,
  input  rename_pkg::rob_ptr_t  complete_rob_idx,
  output logic                  dispatch_ready,
  output rename_pkg::rob_ptr_t  dispatch_rob_idx,
  output rename_pkg::phys_reg_t dispatch_tag,
  output rename_pkg::phys_reg_t dispatch_tag_a,
  output logic                  dispatch_rdy_a,
  output rename_pkg::phys_reg_t dispatch_tag_b,
  output logic                  dispatch_rdy_b,
  output logic                  retire_valid,
  output rename_pkg::op_e       retire_op,
  output rename_pkg::arch_reg_t retire_dest,
  output rename_pkg::phys_reg_t retire_tag,
  output rename_pkg::phys_reg_t retire_tag_old,
  output logic                  halted
);
  import rename_pkg::*;

  logic      fill_en;
  logic      fill_last;
  phys_reg_t fill_tag;
  logic      rob_full;
  logic      fl_empty;
  logic      fl_push;
  phys_reg_t fl_push_tag;
  phys_reg_t map_tag_old;
  logic      comp_tag_valid;
  phys_reg_t comp_tag;
  logic      dispatch_fire;
  logic      alu_fire;
  logic      retire_alu;

  assign dispatch_fire = dispatch_valid && dispatch_ready;
  assign alu_fire      = dispatch_fire && (dispatch_op == OP_ALU);
  assign retire_alu    = retire_valid && (retire_op == OP_ALU);

  // Spare tags during init, freed tags from retirement afterwards
  assign fl_push     = fill_en || retire_alu;
  assign fl_push_tag = fill_en ? fill_tag : retire_tag_old;

  rename_ctrl i_rename_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .fill_last     (fill_last),
    .rob_full      (rob_full),
    .fl_empty      (fl_empty),
    .retire_valid  (retire_valid),
    .retire_op     (retire_op),
    .fill_en       (fill_en),
    .dispatch_ready(dispatch_ready),
    .halted        (halted)
  );

  fill_counter i_fill_counter (
    .clk      (clk),
    .rst_n    (rst_n),
    .fill_en  (fill_en),
    .fill_tag (fill_tag),
    .fill_last(fill_last)
  );

  free_list i_free_list (
    .clk     (clk),
    .rst_n   (rst_n),
    .push    (fl_push),
    .push_tag(fl_push_tag),
    .pop     (alu_fire),
    .head_tag(dispatch_tag),
    .empty   (fl_empty)
  );

  map_table i_map_table (
    .clk           (clk),
    .rst_n         (rst_n),
    .src_a         (dispatch_src_a),
    .src_b         (dispatch_src_b),
    .dest          (dispatch_dest),
    .write_en      (alu_fire),
    .new_tag       (dispatch_tag),
    .comp_tag_valid(comp_tag_valid),
    .comp_tag      (comp_tag),
    .tag_a         (dispatch_tag_a),
    .tag_b         (dispatch_tag_b),
    .tag_old       (map_tag_old),
    .rdy_a         (dispatch_rdy_a),
    .rdy_b         (dispatch_rdy_b)
  );

  reorder_buffer i_reorder_buffer (
    .clk             (clk),
    .rst_n           (rst_n),
    .alloc           (dispatch_fire),
    .alloc_op        (dispatch_op),
    .alloc_dest      (dispatch_dest),
    .alloc_tag       (dispatch_tag),
    .alloc_tag_old   (map_tag_old),
    .complete_valid  (complete_valid),
    .complete_rob_idx(complete_rob_idx),
    .tail            (dispatch_rob_idx),
    .full            (rob_full),
    .comp_tag_valid  (comp_tag_valid),
    .comp_tag        (comp_tag),
    .retire_valid    (retire_valid),
    .retire_op       (retire_op),
    .retire_dest     (retire_dest),
    .retire_tag      (retire_tag),
    .retire_tag_old  (retire_tag_old)
  );

endmodule

`default_nettype wire

// File: logic/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module reorder_buffer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  alloc,
  input  rename_pkg::op_e       alloc_op,
  input  rename_pkg::arch_reg_t alloc_dest,
  input  rename_pkg::phys_reg_t alloc_tag,
  input  rename_pkg::phys_reg_t alloc_tag_old,
  input  logic                  complete_valid,
  input  rename_pkg::rob_ptr_t  complete_rob_idx,
  output rename_pkg::rob_ptr_t  tail,
  output logic                  full,
  output logic                  comp_tag_valid,
  output rename_pkg::phys_reg_t comp_tag,
  output logic                  retire_valid,
  output rename_pkg::op_e       retire_op,
  output rename_pkg::arch_reg_t retire_dest,
  output rename_pkg::phys_reg_t retire_tag,
  output rename_pkg::phys_reg_t retire_tag_old
);
  import rename_pkg::*;

  localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

  op_e                   entry_op      [`ROB_DEPTH];
  arch_reg_t             entry_dest    [`ROB_DEPTH];
  phys_reg_t             entry_tag     [`ROB_DEPTH];
  phys_reg_t             entry_tag_old [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0] entry_done;
  rob_ptr_t              head;
  logic [CNT_W-1:0]      count;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head       <= '0;
      tail       <= '0;
      count      <= '0;
      entry_done <= '0;
    end else begin
      if (alloc) begin
        entry_done[tail] <= 1'b0;
        tail             <= tail + 1'b1;
      end
      // Never names the entry being allocated
      if (complete_valid) entry_done[complete_rob_idx] <= 1'b1;
      if (retire_valid) head <= head + 1'b1;
      case ({alloc, retire_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (alloc) begin
      entry_op[tail]      <= alloc_op;
      entry_dest[tail]    <= alloc_dest;
      entry_tag[tail]     <= alloc_tag;
      entry_tag_old[tail] <= alloc_tag_old;
    end
  end

  assign full = (count == CNT_W'(`ROB_DEPTH));

  // Wakeup only for entries that own a destination
  assign comp_tag_valid = complete_valid && (entry_op[complete_rob_idx] == OP_ALU);
  assign comp_tag       = entry_tag[complete_rob_idx];

  assign retire_valid   = (count != '0) && entry_done[head];
  assign retire_op      = entry_op[head];
  assign retire_dest    = entry_dest[head];
  assign retire_tag     = entry_tag[head];
  assign retire_tag_old = entry_tag_old[head];

endmodule

`default_nettype wire

// File: rename_unit.f
+incdir+logic
logic/rename_pkg.sv
logic/rename_ctrl.sv
logic/fill_counter.sv
logic/free_list.sv
logic/map_table.sv
logic/reorder_buffer.sv
logic/rename_unit.sv
tb/rename_unit_sva.sv
tb/tb_rename_unit.sv

// File: tb/rename_unit_sva.sv
`timescale 1ns/1ps
`default_nettype none

module rename_unit_sva (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 fill_en,
  input logic                 dispatch_valid,
  input logic                 dispatch_ready,
  input rename_pkg::rob_ptr_t dispatch_rob_idx,
  input logic                 retire_valid,
  input logic                 halted
);

  int   fail_count = 0;
  logic fire;

  assign fire = dispatch_valid && dispatch_ready;

  halt_blocks_dispatch: assert property (@(posedge clk) disable iff (!rst_n)
    halted |-> !dispatch_ready)
    else begin
      $error("dispatch_ready high while halted");
      fail_count++;
    end

  no_retire_in_init: assert property (@(posedge clk) disable iff (!rst_n)
    fill_en |-> !retire_valid)
    else begin
      $error("retire_valid high during free-list fill");
      fail_count++;
    end

  // Back-to-back accepts must land in different ROB slots
  rob_idx_advances: assert property (@(posedge clk) disable iff (!rst_n)
    fire |=> (!fire || (dispatch_rob_idx != $past(dispatch_rob_idx))))
    else begin
      $error("dispatch_rob_idx repeated on consecutive accepts");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: tb/tb_rename_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module tb_rename_unit;
  import rename_pkg::*;

  // Reset and init, every dispatch, hold and idle windows, four ROB drains
  localparam int CYCLE_LIMIT = (10 + 32 + 456 + 16 + 4 * `ROB_DEPTH) * 4;

  logic      clk;
  logic      rst_n;
  logic      dispatch_valid;
  op_e       dispatch_op;
  arch_reg_t dispatch_dest;
  arch_reg_t dispatch_src_a;
  arch_reg_t dispatch_src_b;
  logic      complete_valid;
  rob_ptr_t  complete_rob_idx;
  logic      dispatch_ready;
  rob_ptr_t  dispatch_rob_idx;
  phys_reg_t dispatch_tag;
  phys_reg_t dispatch_tag_a;
  logic      dispatch_rdy_a;
  phys_reg_t dispatch_tag_b;
  logic      dispatch_rdy_b;
  logic      retire_valid;
  op_e       retire_op;
  arch_reg_t retire_dest;
  phys_reg_t retire_tag;
  phys_reg_t retire_tag_old;
  logic      halted;

  // Reference model
  phys_reg_t m_tag [`ARCH_REGS];
  logic      m_rdy [`ARCH_REGS];
  phys_reg_t free_q [$];
  op_e       rob_op [$];
  arch_reg_t rob_dest [$];
  phys_reg_t rob_tag [$];
  phys_reg_t rob_old [$];
  bit        rob_done [$];
  rob_ptr_t  pending [$];
  rob_ptr_t  head_idx;
  rob_ptr_t  tail_idx;
  bit        m_run;
  bit        m_halted;

  int        disp_left;
  int        op_mode;
  bit        gen_complete;
  bit        disp_busy;
  rob_ptr_t  seen_rob_idx;
  bit [31:0] lfsr = 32'h4737;
  int        errors;
  int        errors_at;
  int        tests;
  int        alu_total;
  int        recycled;
  int        retired;
  int        dispatched;
  int        cycle_cnt;

  rename_unit i_rename_unit (.*);

  bind rename_unit rename_unit_sva i_rename_unit_sva (
    .clk             (clk),
    .rst_n           (rst_n),
    .fill_en         (fill_en),
    .dispatch_valid  (dispatch_valid),
    .dispatch_ready  (dispatch_ready),
    .dispatch_rob_idx(dispatch_rob_idx),
    .retire_valid    (retire_valid),
    .halted          (halted)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Galois LFSR, one step per bit
  function automatic bit next_bit();
    bit out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ 32'h8020_0003;
    return out;
  endfunction

  function automatic int unsigned rand_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) v = (v << 1) | next_bit();
    return v;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
    errors++;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("Test %s done with %0d errors", name, errors - errors_at);
    errors_at = errors;
  endtask

  // Check at the falling edge, then apply the rising edge to the model and drive
  task automatic step();
    bit        fire;
    bit        exp_ready;
    bit        exp_ret;
    bit        c_dvalid;
    op_e       c_op;
    arch_reg_t c_dest;
    bit        c_valid;
    rob_ptr_t  c_idx;
    int        pos;
    phys_reg_t new_tag;
    op_e       nx_op;
    @(negedge clk);
    exp_ready = m_run && !m_halted && (rob_op.size() < `ROB_DEPTH) && (free_q.size() > 0);
    exp_ret   = (rob_op.size() > 0) && rob_done[0];
    seen_rob_idx = dispatch_rob_idx;
    if (dispatch_ready !== exp_ready) report_mismatch("dispatch_ready", dispatch_ready, exp_ready);
    if (halted !== m_halted) report_mismatch("halted", halted, m_halted);
    if (exp_ready) begin
      if (dispatch_rob_idx !== tail_idx)
        report_mismatch("dispatch_rob_idx", dispatch_rob_idx, tail_idx);
      if (dispatch_tag !== free_q[0]) report_mismatch("dispatch_tag", dispatch_tag, free_q[0]);
      if (dispatch_tag_a !== m_tag[dispatch_src_a])
        report_mismatch("dispatch_tag_a", dispatch_tag_a, m_tag[dispatch_src_a]);
      if (dispatch_rdy_a !== m_rdy[dispatch_src_a])
        report_mismatch("dispatch_rdy_a", dispatch_rdy_a, m_rdy[dispatch_src_a]);
      if (dispatch_tag_b !== m_tag[dispatch_src_b])
        report_mismatch("dispatch_tag_b", dispatch_tag_b, m_tag[dispatch_src_b]);
      if (dispatch_rdy_b !== m_rdy[dispatch_src_b])
        report_mismatch("dispatch_rdy_b", dispatch_rdy_b, m_rdy[dispatch_src_b]);
    end
    if (retire_valid !== exp_ret) report_mismatch("retire_valid", retire_valid, exp_ret);
    if (retire_valid === 1'b1) retired++;
    if (exp_ret) begin
      if (retire_op !== rob_op[0]) report_mismatch("retire_op", retire_op, rob_op[0]);
      if (retire_dest !== rob_dest[0]) report_mismatch("retire_dest", retire_dest, rob_dest[0]);
      if (rob_op[0] == OP_ALU) begin
        if (retire_tag !== rob_tag[0]) report_mismatch("retire_tag", retire_tag, rob_tag[0]);
        if (retire_tag_old !== rob_old[0])
          report_mismatch("retire_tag_old", retire_tag_old, rob_old[0]);
      end
    end
    c_dvalid = dispatch_valid;
    fire     = dispatch_valid && dispatch_ready;
    c_op     = dispatch_op;
    c_dest   = dispatch_dest;
    c_valid  = complete_valid;
    c_idx    = complete_rob_idx;
    if (fire && c_op == OP_ALU) begin
      // Spare tags come out in ascending order after reset
      if (alu_total < 32 && dispatch_tag !== phys_reg_t'(`ARCH_REGS + alu_total))
        report_mismatch("dispatch_tag", dispatch_tag, `ARCH_REGS + alu_total);
      if (alu_total >= 32 && dispatch_tag === free_q[0]) recycled++;
      alu_total++;
    end
    @(posedge clk);
    // Ready-set matches against the map from before this edge
    if (c_valid) begin
      pos = int'(rob_ptr_t'(c_idx - head_idx));
      rob_done[pos] = 1'b1;
      if (rob_op[pos] == OP_ALU) begin
        for (int i = 0; i < `ARCH_REGS; i++) begin
          if (m_tag[i] == rob_tag[pos]) m_rdy[i] = 1'b1;
        end
      end
    end
    if (exp_ret) begin
      if (rob_op[0] == OP_HALT) m_halted = 1'b1;
      if (rob_op[0] == OP_ALU) free_q.push_back(rob_old[0]);
      void'(rob_op.pop_front());
      void'(rob_dest.pop_front());
      void'(rob_tag.pop_front());
      void'(rob_old.pop_front());
      void'(rob_done.pop_front());
      head_idx++;
    end
    if (fire) begin
      new_tag = free_q[0];
      rob_old.push_back(m_tag[c_dest]);
      if (c_op == OP_ALU) begin
        void'(free_q.pop_front());
        m_tag[c_dest] = new_tag;
        m_rdy[c_dest] = 1'b0;
      end
      rob_op.push_back(c_op);
      rob_dest.push_back(c_dest);
      rob_tag.push_back(new_tag);
      rob_done.push_back(1'b0);
      pending.push_back(tail_idx);
      tail_idx++;
      dispatched++;
    end
    if (gen_complete && pending.size() > 0 && rand_bits(2) != 0) begin
      pos = rand_bits(8) % pending.size();
      complete_valid   <= 1'b1;
      complete_rob_idx <= pending[pos];
      pending.delete(pos);
    end else begin
      complete_valid <= 1'b0;
    end
    // A refused instruction stays on the inputs unchanged
    if (!(c_dvalid && !fire)) begin
      if (disp_left > 0) begin
        case (op_mode)
          0:       nx_op = (rand_bits(2) == 0) ? OP_NOP : OP_ALU;
          1:       nx_op = OP_ALU;
          default: nx_op = OP_HALT;
        endcase
        dispatch_valid <= 1'b1;
        dispatch_op    <= nx_op;
        dispatch_dest  <= arch_reg_t'(rand_bits(5));
        dispatch_src_a <= arch_reg_t'(rand_bits(5));
        dispatch_src_b <= arch_reg_t'(rand_bits(5));
        disp_left--;
        disp_busy = 1'b1;
      end else begin
        dispatch_valid <= 1'b0;
        disp_busy = 1'b0;
      end
    end
  endtask

  task automatic run_phase(input int n_disp, input int mode, input bit comp, input bit drain);
    disp_left    = n_disp;
    op_mode      = mode;
    gen_complete = comp;
    do step(); while (disp_left > 0 || disp_busy || (drain && rob_op.size() > 0));
  endtask

  initial begin
    int       lows;
    int       count_at;
    rob_ptr_t held_idx;
    int       sva_fails;
    rst_n            = 1'b0;
    dispatch_valid   = 1'b0;
    dispatch_op      = OP_NOP;
    dispatch_dest    = '0;
    dispatch_src_a   = '0;
    dispatch_src_b   = '0;
    complete_valid   = 1'b0;
    complete_rob_idx = '0;
    for (int i = 0; i < `ARCH_REGS; i++) begin
      m_tag[i] = phys_reg_t'(i);
      m_rdy[i] = 1'b1;
    end
    for (int t = `ARCH_REGS; t < `PHYS_REGS; t++) free_q.push_back(phys_reg_t'(t));
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    lows = 0;
    while (!dispatch_ready && lows < 40) begin
      if (retire_valid !== 1'b0) report_mismatch("retire_valid", retire_valid, 0);
      lows++;
      @(negedge clk);
    end
    if (lows != 32) begin
      $display("dispatch_ready stayed low for %0d cycles after reset instead of 32", lows);
      errors++;
    end
    m_run = 1'b1;
    run_phase(32, 1, 1'b1, 1'b0);
    finish_test("init");

    run_phase(300, 0, 1'b1, 1'b0);
    finish_test("renaming");

    run_phase(0, 0, 1'b1, 1'b1);
    if (retired != dispatched) begin
      $display("%0d instructions dispatched but %0d retired", dispatched, retired);
      errors++;
    end
    finish_test("retire_order");

    count_at = recycled;
    run_phase(100, 1, 1'b1, 1'b1);
    if (recycled - count_at != 100) begin
      $display("Only %0d of 100 ALU dispatches took a recycled tag", recycled - count_at);
      errors++;
    end
    finish_test("recycling");

    run_phase(16, 1, 1'b0, 1'b0);
    held_idx = tail_idx;
    count_at = dispatched;
    disp_left = 1;
    repeat (8) begin
      step();
      if (seen_rob_idx !== held_idx) report_mismatch("dispatch_rob_idx", seen_rob_idx, held_idx);
    end
    if (dispatched != count_at || rob_op.size() != `ROB_DEPTH) begin
      $display("An instruction was accepted while the ROB was full");
      errors++;
    end
    run_phase(0, 1, 1'b1, 1'b1);
    finish_test("backpressure");

    run_phase(6, 0, 1'b1, 1'b0);
    run_phase(1, 2, 1'b1, 1'b1);
    count_at = retired;
    repeat (8) step();
    if (!m_halted || retired != count_at) begin
      $display("Halt did not retire cleanly or a later instruction retired");
      errors++;
    end
    finish_test("halt");

    sva_fails = i_rename_unit.i_rename_unit_sva.fail_count;
    $display("Tests %0d, dispatched %0d, retired %0d, assertion failures %0d, errors %0d",
             tests, dispatched, retired, sva_fails, errors);
    if (errors == 0 && sva_fails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
